// File: flist.f
logic/mips_pkg.sv
logic/instruction_fetch.sv
logic/register_bank.sv
logic/instruction_decode.sv
logic/execute.sv
logic/memory_access.sv
logic/top_mips.sv
verif/wb_checker.sv
verif/tb_top_mips.sv

// File: logic/execute.sv
module execute (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  mips_pkg::id_ex_t   i_id_ex,
    output mips_pkg::ex_mem_t  o_ex_mem
);
    import mips_pkg::*;

    alu_ctrl_t alu_ctrl;
    word_t     operand_b;
    word_t     alu_result;
    word_t     branch_target;
    reg_addr_t dest;

    // alu control from alu_op and funct
    always_comb begin
        case (i_id_ex.ex.alu_op)
            alu_op_add: alu_ctrl = alu_add;
            alu_op_sub: alu_ctrl = alu_sub;
            alu_op_funct: begin
                case (i_id_ex.funct)
                    funct_add: alu_ctrl = alu_add;
                    funct_sub: alu_ctrl = alu_sub;
                    funct_and: alu_ctrl = alu_and;
                    funct_or:  alu_ctrl = alu_or;
                    funct_slt: alu_ctrl = alu_slt;
                    default:   alu_ctrl = alu_add;   // nop lands here
                endcase
            end
            default: alu_ctrl = alu_add;
        endcase
    end

    assign operand_b = i_id_ex.ex.alu_src ? i_id_ex.imm : i_id_ex.data2;

    always_comb begin
        case (alu_ctrl)
            alu_and: alu_result = i_id_ex.data1 & operand_b;
            alu_or:  alu_result = i_id_ex.data1 | operand_b;
            alu_add: alu_result = i_id_ex.data1 + operand_b;
            alu_sub: alu_result = i_id_ex.data1 - operand_b;
            alu_slt: alu_result = {31'd0, $signed(i_id_ex.data1) < $signed(operand_b)};
            default: alu_result = '0;
        endcase
    end

    assign branch_target = i_id_ex.pc_plus4 + {i_id_ex.imm[29:0], 2'b00};
    assign dest          = i_id_ex.ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    ///////////////////////////////////////////////////////////////////////
    // EX/MEM latch
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.wb            <= i_id_ex.wb;
            o_ex_mem.mem           <= i_id_ex.mem;
            o_ex_mem.branch_target <= branch_target;
            o_ex_mem.zero          <= (alu_result == '0);
            o_ex_mem.alu_result    <= alu_result;
            o_ex_mem.store_data    <= i_id_ex.data2;   // rt value for sw
            o_ex_mem.dest          <= dest;
        end
    end

endmodule

// File: logic/instruction_decode.sv
module instruction_decode (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::if_id_t    i_if_id,
    input  mips_pkg::mem_wb_t   i_mem_wb,
    output mips_pkg::id_ex_t    o_id_ex,
    output mips_pkg::wb_event_t o_wb
);
    import mips_pkg::*;

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    funct_t    funct;
    word_t     imm_ext;

    ctrl_wb_t  ctrl_wb;
    ctrl_mem_t ctrl_mem;
    ctrl_ex_t  ctrl_ex;

    word_t     data1;
    word_t     data2;
    word_t     wb_data;

    // instruction fields
    assign opcode  = opcode_t'(i_if_id.instr[31:26]);
    assign rs      = i_if_id.instr[25:21];
    assign rt      = i_if_id.instr[20:16];
    assign rd      = i_if_id.instr[15:11];
    assign funct   = i_if_id.instr[5:0];
    assign imm_ext = {{16{i_if_id.instr[15]}}, i_if_id.instr[15:0]};

    ///////////////////////////////////////////////////////////////////////
    // main control
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_wb  = '0;
        ctrl_mem = '0;
        ctrl_ex  = '0;   // unknown opcodes fall out as nops
        case (opcode)
            op_rtype: begin
                ctrl_wb.reg_write = 1'b1;
                ctrl_ex.reg_dst   = 1'b1;
                ctrl_ex.alu_op    = alu_op_funct;
            end
            op_addi: begin
                ctrl_wb.reg_write = 1'b1;
                ctrl_ex.alu_src   = 1'b1;
                ctrl_ex.alu_op    = alu_op_add;
            end
            op_lw: begin
                ctrl_wb.reg_write  = 1'b1;
                ctrl_wb.mem_to_reg = 1'b1;
                ctrl_mem.mem_read  = 1'b1;
                ctrl_ex.alu_src    = 1'b1;
                ctrl_ex.alu_op     = alu_op_add;
            end
            op_sw: begin
                ctrl_mem.mem_write = 1'b1;
                ctrl_ex.alu_src    = 1'b1;
                ctrl_ex.alu_op     = alu_op_add;
            end
            op_beq: begin
                ctrl_mem.branch = 1'b1;
                ctrl_ex.alu_op  = alu_op_sub;   // equal when difference is zero
            end
            default: ;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // register bank and write-back
    ///////////////////////////////////////////////////////////////////////

    assign wb_data = i_mem_wb.wb.mem_to_reg ? i_mem_wb.read_data : i_mem_wb.alu_result;

    register_bank u_register_bank (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rs         (rs),
        .i_rt         (rt),
        .i_write_reg  (i_mem_wb.dest),
        .i_write_en   (i_mem_wb.wb.reg_write),
        .i_write_data (wb_data),
        .o_data1      (data1),
        .o_data2      (data2)
    );

    assign o_wb.valid = i_mem_wb.wb.reg_write && (i_mem_wb.dest != '0);
    assign o_wb.dest  = i_mem_wb.dest;
    assign o_wb.data  = wb_data;

    // ID/EX latch
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.wb       <= ctrl_wb;
            o_id_ex.mem      <= ctrl_mem;
            o_id_ex.ex       <= ctrl_ex;
            o_id_ex.pc_plus4 <= i_if_id.pc_plus4;
            o_id_ex.data1    <= data1;
            o_id_ex.data2    <= data2;
            o_id_ex.imm      <= imm_ext;
            o_id_ex.rs       <= rs;
            o_id_ex.rt       <= rt;
            o_id_ex.rd       <= rd;
            o_id_ex.funct    <= funct;
        end
    end

endmodule

// File: logic/instruction_fetch.sv
module instruction_fetch (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_run,
    input  logic                 i_imem_we,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    input  mips_pkg::ex_mem_t    i_ex_mem,
    output mips_pkg::if_id_t     o_if_id
);
    import mips_pkg::*;

    word_t      pc;
    word_t      pc_plus4;
    imem_addr_t pc_index;
    logic       take_branch;

    word_t imem [imem_depth];

    assign pc_plus4    = pc + 32'd4;
    assign pc_index    = pc[7:2];   // word index, byte offset dropped
    assign take_branch = i_ex_mem.mem.branch && i_ex_mem.zero;

    // load port, only used while the pipeline is held
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // program counter
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc <= '0;
        end else if (take_branch) begin
            pc <= i_ex_mem.branch_target;   // resolved in execute, no flush
        end else if (i_run) begin
            pc <= pc_plus4;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // IF/ID latch
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_if_id <= '0;
        end else if (i_run) begin
            o_if_id.pc_plus4 <= pc_plus4;
            o_if_id.instr    <= imem[pc_index];
        end else begin
            o_if_id.pc_plus4 <= '0;   // held: feed bubbles so the pipe drains
            o_if_id.instr    <= instr_nop;
        end
    end

endmodule

// File: logic/memory_access.sv
module memory_access (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::mem_wb_t o_mem_wb
);
    import mips_pkg::*;

    dmem_addr_t dmem_index;
    word_t      dmem [dmem_depth];

    assign dmem_index = i_ex_mem.alu_result[7:2];   // word addressed

    // data memory, cleared with the rest of the machine
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_ex_mem.mem.mem_write) begin
            dmem[dmem_index] <= i_ex_mem.store_data;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // MEM/WB latch
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.wb         <= i_ex_mem.wb;
            o_mem_wb.alu_result <= i_ex_mem.alu_result;
            o_mem_wb.dest       <= i_ex_mem.dest;
            if (i_ex_mem.mem.mem_read) begin
                o_mem_wb.read_data <= dmem[dmem_index];   // registered read
            end else begin
                o_mem_wb.read_data <= '0;
            end
        end
    end

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes and widths
    //////////////////////////////////////////////////////////////////////

    localparam int imem_depth = 64;   // instruction words
    localparam int dmem_depth = 64;   // data words
    localparam int reg_count  = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  imem_addr_t;
    typedef logic [5:0]  dmem_addr_t;
    typedef logic [5:0]  funct_t;

    localparam word_t instr_nop = '0;   // sll $0,$0,0

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    localparam funct_t funct_add = 6'h20;
    localparam funct_t funct_sub = 6'h22;
    localparam funct_t funct_and = 6'h24;
    localparam funct_t funct_or  = 6'h25;
    localparam funct_t funct_slt = 6'h2a;

    typedef enum logic [1:0] {
        alu_op_add   = 2'b00,   // address calc, addi
        alu_op_sub   = 2'b01,   // beq compare
        alu_op_funct = 2'b10    // r-type, look at funct
    } alu_op_t;

    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sub = 4'b0110,
        alu_slt = 4'b0111
    } alu_ctrl_t;

    //////////////////////////////////////////////////////////////////////
    // control groups and pipeline latches
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } ctrl_wb_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
    } ctrl_mem_t;

    typedef struct packed {
        logic    reg_dst;   // 1 selects rd
        logic    alu_src;   // 1 selects immediate
        alu_op_t alu_op;
    } ctrl_ex_t;

    typedef struct packed {
        word_t pc_plus4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_wb_t  wb;
        ctrl_mem_t mem;
        ctrl_ex_t  ex;
        word_t     pc_plus4;
        word_t     data1;
        word_t     data2;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        funct_t    funct;
    } id_ex_t;

    typedef struct packed {
        ctrl_wb_t  wb;
        ctrl_mem_t mem;
        word_t     branch_target;
        logic      zero;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        ctrl_wb_t  wb;
        word_t     read_data;
        word_t     alu_result;
        reg_addr_t dest;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;   // one cycle per write to a nonzero register
        reg_addr_t dest;
        word_t     data;
    } wb_event_t;

endpackage

// File: logic/register_bank.sv
module register_bank (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::reg_addr_t i_rs,
    input  mips_pkg::reg_addr_t i_rt,
    input  mips_pkg::reg_addr_t i_write_reg,
    input  logic                i_write_en,
    input  mips_pkg::word_t     i_write_data,
    output mips_pkg::word_t     o_data1,
    output mips_pkg::word_t     o_data2
);
    import mips_pkg::*;

    word_t regs [reg_count];
    logic  wr_live;

    assign wr_live = i_write_en && (i_write_reg != '0);   // $zero stays 0

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    // write-through: same-cycle read sees the value being written
    always_comb begin
        o_data1 = regs[i_rs];
        o_data2 = regs[i_rt];
        if (wr_live && (i_write_reg == i_rs)) begin
            o_data1 = i_write_data;
        end
        if (wr_live && (i_write_reg == i_rt)) begin
            o_data2 = i_write_data;
        end
    end

endmodule

// File: logic/top_mips.sv
module top_mips (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_run,
    input  logic                 i_imem_we,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    output mips_pkg::if_id_t     o_if_id,
    output mips_pkg::id_ex_t     o_id_ex,
    output mips_pkg::ex_mem_t    o_ex_mem,
    output mips_pkg::mem_wb_t    o_mem_wb,
    output mips_pkg::wb_event_t  o_wb
);
    import mips_pkg::*;

    // latches between the stages
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;   // also feeds the branch back to fetch
    mem_wb_t mem_wb;   // back to decode for the register write

    assign o_if_id  = if_id;
    assign o_id_ex  = id_ex;
    assign o_ex_mem = ex_mem;
    assign o_mem_wb = mem_wb;

    ///////////////////////////////////////////////////////////////////////
    // stages
    ///////////////////////////////////////////////////////////////////////

    instruction_fetch u_instruction_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_run       (i_run),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_ex_mem    (ex_mem),
        .o_if_id     (if_id)
    );

    instruction_decode u_instruction_decode (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_if_id  (if_id),
        .i_mem_wb (mem_wb),
        .o_id_ex  (id_ex),
        .o_wb     (o_wb)
    );

    execute u_execute (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex),
        .o_ex_mem (ex_mem)
    );

    memory_access u_memory_access (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb)
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_top_mips -f flist.f || exit 1
out=$(./obj_dir/Vtb_top_mips)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1

// File: verif/tb_top_mips.sv
module tb_top_mips;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    localparam int num_tests  = 6;
    localparam int max_instr  = 16;
    localparam int max_wb     = 8;
    localparam int imem_words = 64;
    localparam int clk_period = 10;

    // MIPS32 encodings
    localparam logic [5:0] enc_addi = 6'h08;
    localparam logic [5:0] enc_lw   = 6'h23;
    localparam logic [5:0] enc_sw   = 6'h2b;
    localparam logic [5:0] enc_beq  = 6'h04;
    localparam logic [5:0] fn_add   = 6'h20;
    localparam logic [5:0] fn_sub   = 6'h22;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_slt   = 6'h2a;
    localparam word_t      nop_word = 32'd0;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_data;
    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    mem_wb_t    mem_wb;
    wb_event_t  wb;

    // stimulus table, one row per test
    logic [127:0] test_name [num_tests];
    word_t        prog      [num_tests][max_instr];
    int           prog_len  [num_tests];
    reg_addr_t    exp_dest  [num_tests][max_wb];
    word_t        exp_data  [num_tests][max_wb];
    int           exp_count [num_tests];
    int           hold_at   [num_tests];   // run cycle where fetch is held
    int           hold_len  [num_tests];

    // current row as seen by the checker
    logic [127:0] cur_name;
    reg_addr_t    cur_dest [max_wb];
    word_t        cur_data [max_wb];
    int           cur_count;
    logic         quiet;
    logic         test_end;
    int           tests_passed;
    int           tests_failed;
    int           limit;

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    top_mips u_top_mips (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_run       (run),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_if_id     (if_id),
        .o_id_ex     (id_ex),
        .o_ex_mem    (ex_mem),
        .o_mem_wb    (mem_wb),
        .o_wb        (wb)
    );

    wb_checker u_wb_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_wb        (wb),
        .i_if_id     (if_id),
        .i_id_ex     (id_ex),
        .i_ex_mem    (ex_mem),
        .i_mem_wb    (mem_wb),
        .i_quiet     (quiet),
        .i_test_end  (test_end),
        .i_name      (cur_name),
        .i_exp_dest  (cur_dest),
        .i_exp_data  (cur_data),
        .i_exp_count (cur_count),
        .o_passed    (tests_passed),
        .o_failed    (tests_failed)
    );

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic add_instr(input int t, input word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    // instruction plus the register write it must produce
    task automatic add_writer(input int t, input word_t w, input reg_addr_t rd,
                              input word_t value);
        add_instr(t, w);
        exp_dest[t][exp_count[t]] = rd;
        exp_data[t][exp_count[t]] = value;
        exp_count[t]++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test programs, writers spaced three slots from their readers
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        word_t       r;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        for (int t = 0; t < num_tests; t++) begin
            prog_len[t]  = 0;
            exp_count[t] = 0;
            hold_at[t]   = 0;
            hold_len[t]  = 0;
        end

        test_name[0] = "arith";
        r = $urandom;
        a = r[15:0];
        b = r[31:16];
        add_writer(0, i_type(enc_addi, 5'd0, 5'd1, a), 5'd1, sext16(a));
        add_writer(0, i_type(enc_addi, 5'd0, 5'd2, b), 5'd2, sext16(b));
        add_instr(0, nop_word);
        add_instr(0, nop_word);
        add_writer(0, r_type(5'd1, 5'd2, 5'd3, fn_add), 5'd3, sext16(a) + sext16(b));
        add_writer(0, r_type(5'd1, 5'd2, 5'd4, fn_sub), 5'd4, sext16(a) - sext16(b));
        add_writer(0, r_type(5'd1, 5'd2, 5'd5, fn_and), 5'd5, sext16(a) & sext16(b));
        add_writer(0, r_type(5'd1, 5'd2, 5'd6, fn_or), 5'd6, sext16(a) | sext16(b));

        test_name[1] = "slt_signed";
        r = $urandom;
        a = {1'b1, r[14:0]};          // negative
        b = {1'b0, r[29:16], 1'b1};   // positive
        add_writer(1, i_type(enc_addi, 5'd0, 5'd1, a), 5'd1, sext16(a));
        add_writer(1, i_type(enc_addi, 5'd0, 5'd2, b), 5'd2, sext16(b));
        add_instr(1, nop_word);
        add_instr(1, nop_word);
        add_writer(1, r_type(5'd1, 5'd2, 5'd3, fn_slt), 5'd3, 32'd1);
        add_writer(1, r_type(5'd2, 5'd1, 5'd4, fn_slt), 5'd4, 32'd0);
        add_writer(1, r_type(5'd1, 5'd1, 5'd5, fn_slt), 5'd5, 32'd0);

        test_name[2] = "store_load";
        r = $urandom;
        a = r[15:0];
        b = r[31:16];
        add_writer(2, i_type(enc_addi, 5'd0, 5'd1, a), 5'd1, sext16(a));
        add_writer(2, i_type(enc_addi, 5'd0, 5'd2, b), 5'd2, sext16(b));
        add_instr(2, nop_word);
        add_instr(2, nop_word);
        add_instr(2, i_type(enc_sw, 5'd0, 5'd1, 16'd0));
        add_instr(2, i_type(enc_sw, 5'd0, 5'd2, 16'd8));
        add_instr(2, i_type(enc_sw, 5'd0, 5'd1, 16'd252));   // top data word
        add_writer(2, i_type(enc_lw, 5'd0, 5'd3, 16'd0), 5'd3, sext16(a));
        add_writer(2, i_type(enc_lw, 5'd0, 5'd4, 16'd8), 5'd4, sext16(b));
        add_writer(2, i_type(enc_lw, 5'd0, 5'd5, 16'd252), 5'd5, sext16(a));
        add_writer(2, i_type(enc_lw, 5'd0, 5'd6, 16'd4), 5'd6, 32'd0);   // never stored

        test_name[3] = "branch";
        r = $urandom;
        a = {r[15:1], 1'b0};   // even, so never equal to r3
        add_writer(3, i_type(enc_addi, 5'd0, 5'd1, a), 5'd1, sext16(a));
        add_writer(3, i_type(enc_addi, 5'd0, 5'd2, a), 5'd2, sext16(a));
        add_instr(3, nop_word);
        add_instr(3, nop_word);
        add_instr(3, i_type(enc_beq, 5'd1, 5'd2, 16'd4));   // taken, lands on word 9
        add_writer(3, i_type(enc_addi, 5'd0, 5'd3, 16'd1), 5'd3, 32'd1);
        add_writer(3, i_type(enc_addi, 5'd0, 5'd4, 16'd2), 5'd4, 32'd2);
        add_writer(3, i_type(enc_addi, 5'd0, 5'd5, 16'd3), 5'd5, 32'd3);
        add_instr(3, i_type(enc_addi, 5'd0, 5'd6, 16'd99));   // skipped
        add_instr(3, i_type(enc_beq, 5'd1, 5'd3, 16'd1));     // falls through
        add_writer(3, i_type(enc_addi, 5'd0, 5'd7, 16'd7), 5'd7, 32'd7);
        add_writer(3, i_type(enc_addi, 5'd0, 5'd8, 16'd8), 5'd8, 32'd8);

        test_name[4] = "zero_reg";
        r = $urandom;
        a = r[15:0];
        b = r[31:16];
        // r5 and r7 hold values from the last test until reset
        add_writer(4, r_type(5'd5, 5'd7, 5'd4, fn_or), 5'd4, 32'd0);
        add_instr(4, i_type(enc_addi, 5'd0, 5'd0, a));
        add_writer(4, i_type(enc_addi, 5'd0, 5'd1, b), 5'd1, sext16(b));
        add_instr(4, nop_word);
        add_instr(4, nop_word);
        add_writer(4, r_type(5'd0, 5'd1, 5'd2, fn_add), 5'd2, sext16(b));
        add_writer(4, r_type(5'd0, 5'd0, 5'd3, fn_or), 5'd3, 32'd0);
        add_instr(4, r_type(5'd1, 5'd1, 5'd0, fn_add));

        test_name[5] = "run_hold";
        r = $urandom;
        a = r[15:0];
        b = r[31:16];
        r = $urandom;
        c = r[15:0];
        add_writer(5, i_type(enc_addi, 5'd0, 5'd1, a), 5'd1, sext16(a));
        add_writer(5, i_type(enc_addi, 5'd0, 5'd2, b), 5'd2, sext16(b));
        add_writer(5, i_type(enc_addi, 5'd0, 5'd3, c), 5'd3, sext16(c));
        add_instr(5, nop_word);
        add_writer(5, r_type(5'd1, 5'd2, 5'd4, fn_add), 5'd4, sext16(a) + sext16(b));
        add_writer(5, r_type(5'd2, 5'd3, 5'd5, fn_add), 5'd5, sext16(b) + sext16(c));
        add_writer(5, i_type(enc_addi, 5'd0, 5'd6, a), 5'd6, sext16(a));
        hold_at[5]  = 4;   // PC parked on the first add
        hold_len[5] = 14;
    endtask

    // whole memory is written, unused words get an unknown opcode
    task automatic load_program(input int t);
        for (int a = 0; a < imem_words; a++) begin
            imem_we   = 1'b1;
            imem_addr = a[5:0];
            if (a < prog_len[t]) begin
                imem_data = prog[t][a];
            end else begin
                imem_data = {6'h3f, 20'd0, a[5:0]};
            end
            next_cycle();
        end
        imem_we = 1'b0;
    endtask

    task automatic run_test(input int t);
        cur_name  = test_name[t];
        cur_count = exp_count[t];
        for (int i = 0; i < max_wb; i++) begin
            cur_dest[i] = exp_dest[t][i];
            cur_data[i] = exp_data[t][i];
        end
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        load_program(t);
        run = 1'b1;
        for (int n = 0; n < prog_len[t] + 8; n++) begin
            if (hold_len[t] > 0 && n == hold_at[t]) begin
                run = 1'b0;
                for (int h = 0; h < hold_len[t]; h++) begin
                    quiet = (h >= 6);   // pipe has drained by now
                    next_cycle();
                end
                quiet = 1'b0;
                run   = 1'b1;
            end
            next_cycle();
        end
        run = 1'b0;
        repeat (6) next_cycle();   // drain
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h9780406b));
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        quiet     = 1'b0;
        test_end  = 1'b0;
        cur_name  = '0;
        cur_count = 0;
        for (int i = 0; i < max_wb; i++) begin
            cur_dest[i] = '0;
            cur_data[i] = '0;
        end
        build_table();

        // watchdog from the test lengths plus a margin
        limit = 100;
        for (int t = 0; t < num_tests; t++) begin
            limit += 10 + imem_words + prog_len[t] + 8 + hold_len[t] + 6 + 1;
        end
        fork
            begin
                #(limit * clk_period);
                $display("timeout: run did not finish within %0d cycles", limit);
                $display("CHECKS FAILED");
                $finish;
            end
        join_none

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d passed, %0d failed",
                 num_tests, tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == num_tests) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/wb_checker.sv
module wb_checker (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::wb_event_t i_wb,
    input  mips_pkg::if_id_t    i_if_id,
    input  mips_pkg::id_ex_t    i_id_ex,
    input  mips_pkg::ex_mem_t   i_ex_mem,
    input  mips_pkg::mem_wb_t   i_mem_wb,
    input  logic                i_quiet,
    input  logic                i_test_end,
    input  logic [127:0]        i_name,
    input  mips_pkg::reg_addr_t i_exp_dest [8],
    input  mips_pkg::word_t     i_exp_data [8],
    input  int                  i_exp_count,
    output int                  o_passed,
    output int                  o_failed
);
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    int   seen;     // write-backs so far in this test
    int   errors;
    logic rst_q;    // reset as seen by the last rising edge

    initial begin
        seen     = 0;
        errors   = 0;
        o_passed = 0;
        o_failed = 0;
    end

    always @(posedge i_clk) begin
        rst_q <= i_rst_n;
    end

    // sample away from the rising edge, everything is settled here
    always @(negedge i_clk) begin
        // every latch holds an all-zero nop once reset has been clocked in
        if (!rst_q) begin
            if (i_if_id != '0 || i_id_ex != '0 || i_ex_mem != '0 ||
                i_mem_wb != '0 || i_wb.valid) begin
                $display("error in test %0s: pipeline latches not cleared by reset", i_name);
                errors++;
            end
        end

        if (i_wb.valid) begin
            if (i_quiet) begin
                $display("error in test %0s: write-back to r%0d while fetch was held and drained",
                         i_name, i_wb.dest);
                errors++;
            end else if (seen >= i_exp_count) begin
                $display("error in test %0s: unexpected extra write-back r%0d = %h",
                         i_name, i_wb.dest, i_wb.data);
                errors++;
            end else if (i_wb.dest != i_exp_dest[seen] || i_wb.data != i_exp_data[seen]) begin
                $display("mismatch in test %0s, write-back %0d: expected r%0d = %h, actual r%0d = %h",
                         i_name, seen, i_exp_dest[seen], i_exp_data[seen], i_wb.dest, i_wb.data);
                errors++;
            end
            seen++;
        end

        ///////////////////////////////////////////////////////////////////////
        // end of test
        ///////////////////////////////////////////////////////////////////////
        if (i_test_end) begin
            if (seen < i_exp_count) begin
                $display("error in test %0s: only %0d of %0d expected write-backs arrived",
                         i_name, seen, i_exp_count);
                errors++;
            end
            if (errors == 0) begin
                o_passed++;
                $display("test %0s: ok, %0d write-backs", i_name, seen);
            end else begin
                o_failed++;
                $display("test %0s: failed with %0d errors", i_name, errors);
            end
            seen   = 0;
            errors = 0;
        end
    end

endmodule
